// File: files.f
+incdir+.
accel_port_pkg.sv
raster_pkg.sv
line_drawer_accel_adapter.sv
line_drawer.sv
pixel_credit_queue.sv
line_accel_top.sv
tb_line_accel.sv

// File: run_sim.sh
#!/bin/sh
# builds the line accelerator testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_line_accel -o tb_line_accel
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_line_accel)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^>>> PASS$'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: tb_line_model.svh
`ifndef TB_LINE_MODEL_SVH
`define TB_LINE_MODEL_SVH

// pixels still to come out of the DUT, oldest first
pixel_t expected_q[$];

function automatic int abs_diff(input int a, input int b);
    return (a > b) ? a - b : b - a;
endfunction

// a line covers its larger extent plus one pixels
function automatic int line_length(input int x1, input int y1, input int x2, input int y2);
    int dx;
    int dy;
    dx = abs_diff(x1, x2);
    dy = abs_diff(y1, y2);
    return ((dx > dy) ? dx : dy) + 1;
endfunction

// integer Bresenham walk, valid in every octant
task automatic append_line_pixels(input int x1, input int y1, input int x2, input int y2);
    int     x;
    int     y;
    int     dx;
    int     dy;
    int     sx;
    int     sy;
    int     err;
    int     e2;
    bit     reached;
    pixel_t p;
    x = x1;
    y = y1;
    dx = abs_diff(x1, x2);
    dy = -abs_diff(y1, y2);
    sx = (x2 >= x1) ? 1 : -1;
    sy = (y2 >= y1) ? 1 : -1;
    err = dx + dy;
    reached = 1'b0;
    while (!reached) begin
        p.x = x[`COORD_W-1:0];
        p.y = y[`COORD_W-1:0];
        expected_q.push_back(p);
        if (x == x2 && y == y2) begin
            reached = 1'b1;
        end else begin
            e2 = 2 * err;
            if (e2 >= dy) begin
                err = err + dy;
                x = x + sx;
            end
            if (e2 <= dx) begin
                err = err + dx;
                y = y + sy;
            end
        end
    end
endtask

task automatic report_value(input string name, input int expected, input int actual);
    $display("FAIL t=%0t %s expected %0d got %0d", $time, name, expected, actual);
    error_count++;
endtask

task automatic report_problem(input string what);
    $display("ERROR t=%0t %s", $time, what);
    error_count++;
endtask

task automatic close_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
        $display("test %0d %s: ok", tests_run, name);
        tests_passed++;
    end else begin
        $display("test %0d %s: %0d errors", tests_run, name, error_count - errors_before);
    end
    tests_run++;
endtask

`endif

// File: tb_line_accel.sv
`timescale 1ns/1ps
`include "line_accel_config.svh"

module tb_line_accel
    import accel_port_pkg::*;
    import raster_pkg::*;
();

    localparam int NUM_LINES   = 30;
    localparam int CYCLE_LIMIT = 200 * NUM_LINES + 2000;

    logic        clk;
    logic        rst_n;
    logic        can_read;
    logic        can_write;
    logic        read_enable;
    logic        write_enable;
    accel_word_t read_data;
    accel_word_t write_data;
    logic        out_valid;
    pixel_t      out_pix;
    logic        credit_return;

    integer seed;
    int     error_count = 0;
    int     tests_run = 0;
    int     tests_passed = 0;
    int     cycle_count = 0;
    int     pixels_seen = 0;
    int     outstanding = 0;
    int     max_outstanding = 0;
    int     return_due[$];
    pixel_t expected_pix;

    `include "tb_line_model.svh"

    line_accel_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .can_read      (can_read),
        .can_write     (can_write),
        .read_enable   (read_enable),
        .write_enable  (write_enable),
        .read_data     (read_data),
        .write_data    (write_data),
        .out_valid     (out_valid),
        .out_pix       (out_pix),
        .credit_return (credit_return)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("ERROR t=%0t run stopped at the cycle limit of %0d", $time, CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    // outputs are sampled at the falling edge, half a cycle after the rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (credit_return) begin
                outstanding--;
            end
            if (out_valid) begin
                assert (expected_q.size() != 0)
                    else report_problem("out_valid seen while no pixel was expected");
                if (expected_q.size() != 0) begin
                    expected_pix = expected_q.pop_front();
                    assert (out_pix.x == expected_pix.x)
                        else report_value("out_pix.x", expected_pix.x, out_pix.x);
                    assert (out_pix.y == expected_pix.y)
                        else report_value("out_pix.y", expected_pix.y, out_pix.y);
                end
                outstanding++;
                pixels_seen++;
                return_due.push_back(cycle_count + 1 + ($unsigned($random(seed)) % 6));
            end
            if (outstanding > max_outstanding) begin
                max_outstanding = outstanding;
            end
            assert (outstanding <= `PIX_CREDITS)
                else report_value("pixels in flight limit", `PIX_CREDITS, outstanding);
        end
    end

    // the sink frees one buffer slot per cycle, oldest pixel first
    always @(posedge clk) begin
        #1;
        if (return_due.size() != 0 && return_due[0] <= cycle_count) begin
            credit_return = 1'b1;
            return_due.delete(0);
        end else begin
            credit_return = 1'b0;
        end
    end

    task automatic wait_drive_point();
        @(posedge clk);
        #1;
    endtask

    function automatic int rand_coord();
        return $unsigned($random(seed)) % 41;
    endfunction

    task automatic write_word(input accel_word_t value);
        int gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) wait_drive_point();
        while (!can_write) begin
            wait_drive_point();
        end
        write_enable = 1'b1;
        write_data   = value;
        wait_drive_point();
        write_enable = 1'b0;
    endtask

    task automatic check_reset_state();
        int errors_before;
        errors_before = error_count;
        assert (can_write) else report_value("can_write", 1, can_write);
        assert (can_read) else report_value("can_read", 1, can_read);
        assert (read_data == 0) else report_value("read_data", 0, read_data);
        repeat (8) begin
            assert (!out_valid) else report_value("out_valid", 0, out_valid);
            wait_drive_point();
        end
        close_test("reset state", errors_before);
    endtask

    task automatic run_line(input int idx, input int x1, input int y1, input int x2,
                            input int y2);
        int errors_before;
        int n;
        int seen_before;
        int quiet;
        errors_before = error_count;
        n = line_length(x1, y1, x2, y2);
        seen_before = pixels_seen;
        append_line_pixels(x1, y1, x2, y2);
        write_word(x1[`COORD_W-1:0]);
        write_word(y1[`COORD_W-1:0]);
        write_word(x2[`COORD_W-1:0]);
        write_word(y2[`COORD_W-1:0]);
        // start, n pixels and done take at least n + 2 cycles before the port reopens
        for (quiet = 0; quiet < n + 2; quiet++) begin
            assert (!can_write)
                else report_problem("can_write went high while the line was being drawn");
            wait_drive_point();
        end
        while (!can_write) begin
            wait_drive_point();
        end
        // once the port reopens, every pixel not yet out must already sit in the queue
        assert (n - (pixels_seen - seen_before) <= `PIXQ_DEPTH)
            else report_problem("can_write reopened before the line was fully drawn");
        while (pixels_seen - seen_before < n) begin
            wait_drive_point();
        end
        repeat (2) wait_drive_point();
        assert (pixels_seen - seen_before == n)
            else report_value("pixels per line", n, pixels_seen - seen_before);
        assert (expected_q.size() == 0)
            else report_problem("pixels of the line never came out");
        assert (can_read) else report_value("can_read", 1, can_read);
        assert (read_data == idx + 1) else report_value("read_data", idx + 1, read_data);
        read_enable = 1'b1;
        wait_drive_point();
        read_enable = 1'b0;
        assert (read_data == idx + 1) else report_value("read_data", idx + 1, read_data);
        close_test($sformatf("line (%0d,%0d)->(%0d,%0d) %0d pixels", x1, y1, x2, y2, n),
                   errors_before);
    endtask

    initial begin
        int idx;
        int x1;
        int y1;
        int x2;
        int y2;
        int errors_before;
        seed          = 61;
        rst_n         = 1'b0;
        read_enable   = 1'b0;
        write_enable  = 1'b0;
        write_data    = '0;
        credit_return = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_reset_state();

        // the first three lines are a point, a horizontal and a vertical line
        for (idx = 0; idx < NUM_LINES; idx++) begin
            x1 = rand_coord();
            y1 = rand_coord();
            x2 = rand_coord();
            y2 = rand_coord();
            if (idx == 0) begin
                x2 = x1;
                y2 = y1;
            end else if (idx == 1) begin
                y2 = y1;
            end else if (idx == 2) begin
                x2 = x1;
            end
            run_line(idx, x1, y1, x2, y2);
        end

        errors_before = error_count;
        while (return_due.size() != 0) begin
            wait_drive_point();
        end
        repeat (2) wait_drive_point();
        assert (outstanding == 0) else report_value("pixels in flight at end", 0, outstanding);
        assert (max_outstanding <= `PIX_CREDITS)
            else report_value("peak pixels in flight", `PIX_CREDITS, max_outstanding);
        close_test($sformatf("credit window peak %0d of %0d", max_outstanding, `PIX_CREDITS),
                   errors_before);

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_passed, tests_run - tests_passed, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: line_accel_top.sv
`timescale 1ns/1ps

module line_accel_top
    import accel_port_pkg::*;
    import raster_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    output logic        can_read,
    output logic        can_write,
    input  logic        read_enable,
    input  logic        write_enable,
    output accel_word_t read_data,
    input  accel_word_t write_data,
    output logic        out_valid,
    output pixel_t      out_pix,
    input  logic        credit_return
);

    logic      start;
    logic      done;
    line_cmd_t cmd;
    logic      pix_valid;
    logic      pix_ready;
    pixel_t    pix;

    line_drawer_accel_adapter u_adapter (
        .clk          (clk),
        .rst_n        (rst_n),
        .can_read     (can_read),
        .can_write    (can_write),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .read_data    (read_data),
        .write_data   (write_data),
        .start        (start),
        .done         (done),
        .cmd          (cmd)
    );

    // the adapter sequences lines by done, so ready is left open here
    line_drawer u_drawer (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .cmd       (cmd),
        .ready     (),
        .done      (done),
        .pix_valid (pix_valid),
        .pix       (pix),
        .pix_ready (pix_ready)
    );

    pixel_credit_queue u_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .pix_valid     (pix_valid),
        .pix           (pix),
        .pix_ready     (pix_ready),
        .out_valid     (out_valid),
        .out_pix       (out_pix),
        .credit_return (credit_return)
    );

endmodule

// File: pixel_credit_queue.sv
`timescale 1ns/1ps
`include "line_accel_config.svh"

module pixel_credit_queue
    import raster_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   pix_valid,
    input  pixel_t pix,
    output logic   pix_ready,
    output logic   out_valid,
    output pixel_t out_pix,
    input  logic   credit_return
);

    pixel_t mem [`PIXQ_DEPTH];

    logic [$clog2(`PIXQ_DEPTH)-1:0]    wr_ptr;
    logic [$clog2(`PIXQ_DEPTH)-1:0]    rd_ptr;
    logic [$clog2(`PIXQ_DEPTH+1)-1:0]  count;
    logic [$clog2(`PIX_CREDITS+1)-1:0] credits;
    logic                              push;
    logic                              pop;

    assign pix_ready = (count != `PIXQ_DEPTH);
    assign push      = pix_valid && pix_ready;

    // the head leaves in any cycle the consumer still has room for it
    assign out_valid = (count != 0) && (credits != 0);
    assign pop       = out_valid;
    assign out_pix   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= pix;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == `PIXQ_DEPTH - 1) ? '0 : wr_ptr + 1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == `PIXQ_DEPTH - 1) ? '0 : rd_ptr + 1;
            end
            if (push && !pop) begin
                count <= count + 1;
            end else if (pop && !push) begin
                count <= count - 1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= `PIX_CREDITS;
        end else if (pop && !credit_return) begin
            credits <= credits - 1;
        end else if (credit_return && !pop) begin
            credits <= credits + 1;
        end
    end

    // a consumer returning more credits than it was given would wrap the counter
    assert property (@(posedge clk) disable iff (!rst_n)
        credit_return && !pop |-> credits < `PIX_CREDITS)
        else $error("credit returned while all credits are held");

    // the write pointer runs ahead of the read pointer by the number of stored entries
    assert property (@(posedge clk) disable iff (!rst_n)
        wr_ptr == rd_ptr + count[$clog2(`PIXQ_DEPTH)-1:0])
        else $error("pixel queue pointers and entry count disagree");

endmodule

// File: line_drawer.sv
`timescale 1ns/1ps
`include "line_accel_config.svh"

module line_drawer
    import raster_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  line_cmd_t cmd,
    output logic      ready,
    output logic      done,
    output logic      pix_valid,
    output pixel_t    pix,
    input  logic      pix_ready
);

    drawer_state_e state;

    coord_t cur_x;
    coord_t cur_y;
    coord_t end_x;
    coord_t end_y;
    logic   step_x_neg;
    logic   step_y_neg;

    // dx_r holds +|dx| and dy_r holds -|dy|, as in the integer all-octant form
    logic signed [`ERR_W-1:0] dx_r;
    logic signed [`ERR_W-1:0] dy_r;
    logic signed [`ERR_W-1:0] err;

    coord_t                   abs_dx;
    coord_t                   abs_dy;
    logic signed [`ERR_W-1:0] dx_load;
    logic signed [`ERR_W-1:0] dy_load;
    logic signed [`ERR_W-1:0] e2;
    logic                     move_x;
    logic                     move_y;
    logic                     at_end;
    logic                     accept;

    assign abs_dx = (cmd.x2 >= cmd.x1) ? cmd.x2 - cmd.x1 : cmd.x1 - cmd.x2;
    assign abs_dy = (cmd.y2 >= cmd.y1) ? cmd.y2 - cmd.y1 : cmd.y1 - cmd.y2;

    assign dx_load = {{(`ERR_W - `COORD_W){1'b0}}, abs_dx};
    assign dy_load = -{{(`ERR_W - `COORD_W){1'b0}}, abs_dy};

    assign e2     = err <<< 1;
    assign move_x = (e2 >= dy_r);
    assign move_y = (e2 <= dx_r);
    assign at_end = (cur_x == end_x) && (cur_y == end_y);
    assign accept = (state == STEP) && pix_ready;

    assign ready     = (state == IDLE);
    assign done      = (state == FINISH);
    assign pix_valid = (state == STEP);
    assign pix       = '{x: cur_x, y: cur_y};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start) state <= STEP;
                end
                STEP: begin
                    if (accept && at_end) state <= FINISH;
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // a stalled pixel keeps its coordinates and error term until it is taken
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            cur_x      <= cmd.x1;
            cur_y      <= cmd.y1;
            end_x      <= cmd.x2;
            end_y      <= cmd.y2;
            step_x_neg <= (cmd.x2 < cmd.x1);
            step_y_neg <= (cmd.y2 < cmd.y1);
            dx_r       <= dx_load;
            dy_r       <= dy_load;
            err        <= dx_load + dy_load;
        end else if (accept && !at_end) begin
            if (move_x) begin
                cur_x <= step_x_neg ? cur_x - 1 : cur_x + 1;
            end
            if (move_y) begin
                cur_y <= step_y_neg ? cur_y - 1 : cur_y + 1;
            end
            err <= err + (move_x ? dy_r : '0) + (move_y ? dx_r : '0);
        end
    end

    // the adapter must wait for the previous line to finish
    assert property (@(posedge clk) disable iff (!rst_n) start |-> ready)
        else $error("start received while the line engine is busy");

endmodule

// File: line_drawer_accel_adapter.sv
`timescale 1ns/1ps

module line_drawer_accel_adapter
    import accel_port_pkg::*;
    import raster_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    output logic        can_read,
    output logic        can_write,
    input  logic        read_enable,
    input  logic        write_enable,
    output accel_word_t read_data,
    input  accel_word_t write_data,
    output logic        start,
    input  logic        done,
    output line_cmd_t   cmd
);

    adapter_state_e state;
    accel_word_t    line_count;

    assign can_write = (state == READ_X1) || (state == READ_Y1) ||
                       (state == READ_X2) || (state == READ_Y2);

    // reads are only offered while no coordinate of a new line has been taken
    assign can_read  = (state == READ_X1);
    assign read_data = line_count;

    assign start = (state == START);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= READ_X1;
        end else begin
            case (state)
                READ_X1: begin
                    if (write_enable) state <= READ_Y1;
                end
                READ_Y1: begin
                    if (write_enable) state <= READ_X2;
                end
                READ_X2: begin
                    if (write_enable) state <= READ_Y2;
                end
                READ_Y2: begin
                    if (write_enable) state <= START;
                end
                START: begin
                    state <= WORK;
                end
                WORK: begin
                    if (done) state <= READ_X1;
                end
                default: begin
                    state <= READ_X1;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_count <= '0;
        end else if (state == WORK && done) begin
            line_count <= line_count + 1;
        end
    end

    // the engine reads cmd until done, so fields only change in the read states
    always_ff @(posedge clk) begin
        if (write_enable) begin
            case (state)
                READ_X1: cmd.x1 <= write_data;
                READ_Y1: cmd.y1 <= write_data;
                READ_X2: cmd.x2 <= write_data;
                READ_Y2: cmd.y2 <= write_data;
                default: begin
                end
            endcase
        end
    end

    // the host must honour both flags of the port
    assert property (@(posedge clk) disable iff (!rst_n) write_enable |-> can_write)
        else $error("write_enable while the adapter is busy");

    assert property (@(posedge clk) disable iff (!rst_n) read_enable |-> can_read)
        else $error("read_enable while a line is being taken or drawn");

endmodule

// File: raster_pkg.sv
`include "line_accel_config.svh"

package raster_pkg;

    typedef logic [`COORD_W-1:0] coord_t;

    // both endpoints of one line, all coordinates unsigned
    typedef struct packed {
        coord_t x1;
        coord_t y1;
        coord_t x2;
        coord_t y2;
    } line_cmd_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pixel_t;

    // the engine sits in STEP for every pixel it offers, FINISH carries done
    typedef enum logic [1:0] {
        IDLE,
        STEP,
        FINISH
    } drawer_state_e;

endpackage

// File: accel_port_pkg.sv
`include "line_accel_config.svh"

package accel_port_pkg;

    // one data word on the host accelerator port
    typedef logic [`COORD_W-1:0] accel_word_t;

    // the host writes x1, y1, x2, y2 in that order, then the line runs
    typedef enum logic [2:0] {
        READ_X1,
        READ_Y1,
        READ_X2,
        READ_Y2,
        START,
        WORK
    } adapter_state_e;

endpackage

// File: line_accel_config.svh
`ifndef LINE_ACCEL_CONFIG_SVH
`define LINE_ACCEL_CONFIG_SVH

// width of one coordinate and of one host port word
`define COORD_W 16

// Bresenham error term needs headroom for the doubled error and both extents
`define ERR_W (`COORD_W + 3)

// entries in the pixel queue between the engine and the consumer
`define PIXQ_DEPTH 4

// credits granted to the pixel queue after reset
`define PIX_CREDITS 3

`endif
